// ==== hw/adc_pkg.sv ====
// shared definitions for the multi-slope adc controller
// sequencer and switch encodings, spi register map, conversion timing
package adc_pkg;

  ////////////////////
  // encodings

  // conversion sequencer states
  typedef enum logic [2:0] {
    SEQ_INIT    = 3'd0,
    SEQ_RUNUP   = 3'd1,
    SEQ_RUNDOWN = 3'd2,
    SEQ_DONE    = 3'd3
  } seq_state_t;

  // integrator input switch code, bit order is {sig, neg, pos}
  typedef enum logic [2:0] {
    MUX_OFF     = 3'b000,
    MUX_POS_REF = 3'b001,
    MUX_NEG_REF = 3'b010
  } mux_sel_t;

  ////////////////////
  // spi frame and register map

  // width of each result count, also the data field of a frame
  localparam int COUNT_W    = 24;
  // 8 address bits then 24 data bits
  localparam int FRAME_BITS = 32;
  localparam int ADDR_W     = 8;

  localparam logic [ADDR_W-1:0] ADDR_LED           = 8'd7;
  localparam logic [ADDR_W-1:0] ADDR_COUNT_UP      = 8'd9;
  localparam logic [ADDR_W-1:0] ADDR_COUNT_DOWN    = 8'd10;
  localparam logic [ADDR_W-1:0] ADDR_COUNT_RUNDOWN = 8'd11;
  // shares its value with the rundown count, only acts on a write
  localparam logic [ADDR_W-1:0] ADDR_SOFT_RESET    = 8'd11;

  // address bit that turns a frame into a pure read
  localparam int ADDR_READ_ONLY_BIT = 7;

  // led register after reset or soft reset, red and blue on
  localparam logic [COUNT_W-1:0] LED_RESET_VALUE = 24'd5;

  ////////////////////
  // conversion timing, in clk cycles

  // settle time before each run-up
  localparam int INIT_CLKS    = 20;
  // length of one run-up phase
  localparam int PHASE_CLKS   = 16;
  localparam int RUNUP_PHASES = 40;
  // interrupt low time after a result
  localparam int DONE_CLKS    = 4;

endpackage

// ==== hw/adc_top.sv ====
// top level of the multi-slope adc controller
// spi port, register bank and modulation sequencer wired to the board pins
`timescale 1ns/1ps

module adc_top (
  input  logic clk,
  input  logic reset,
  // host spi
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso,
  output logic interrupt_n,
  // integrator and comparator
  input  logic cmp_out,
  output logic int_in_p_ctl,
  output logic int_in_n_ctl,
  output logic int_in_sig_ctl,
  output logic cmp_latch_ctl,
  // status leds
  output logic led_r,
  output logic led_g,
  output logic led_b
);
  import adc_pkg::*;

  logic               addr_valid;
  logic [ADDR_W-1:0]  rd_addr;
  logic [COUNT_W-1:0] rd_data;
  logic               frame_end;
  logic [ADDR_W-1:0]  frame_addr;
  logic [COUNT_W-1:0] frame_data;
  logic [COUNT_W-1:0] last_up;
  logic [COUNT_W-1:0] last_down;
  logic [COUNT_W-1:0] last_rundown;
  logic [COUNT_W-1:0] led_reg;
  mux_sel_t           mux;

  // switch code bits are {sig, neg, pos}
  assign {int_in_sig_ctl, int_in_n_ctl, int_in_p_ctl} = mux;
  assign {led_b, led_g, led_r} = led_reg[2:0];

  spi_slave_port spi_slave_port_i (
    .clk        (clk),
    .reset      (reset),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso),
    .addr_valid (addr_valid),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .frame_end  (frame_end),
    .frame_addr (frame_addr),
    .frame_data (frame_data)
  );

  register_bank register_bank_i (
    .clk          (clk),
    .reset        (reset),
    .addr_valid   (addr_valid),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .frame_end    (frame_end),
    .frame_addr   (frame_addr),
    .frame_data   (frame_data),
    .last_up      (last_up),
    .last_down    (last_down),
    .last_rundown (last_rundown),
    .led_reg      (led_reg)
  );

  modulation_sequencer modulation_sequencer_i (
    .clk           (clk),
    .reset         (reset),
    .cmp_out       (cmp_out),
    .mux           (mux),
    .cmp_latch_ctl (cmp_latch_ctl),
    .interrupt_n   (interrupt_n),
    .last_up       (last_up),
    .last_down     (last_down),
    .last_rundown  (last_rundown)
  );

endmodule

// ==== hw/modulation_sequencer.sv ====
// multi-slope modulation sequencer
// run-up with comparator feedback, run-down to zero cross, result snapshot
`timescale 1ns/1ps

module modulation_sequencer (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cmp_out,
  output adc_pkg::mux_sel_t           mux,
  output logic                        cmp_latch_ctl,
  output logic                        interrupt_n,
  output logic [adc_pkg::COUNT_W-1:0] last_up,
  output logic [adc_pkg::COUNT_W-1:0] last_down,
  output logic [adc_pkg::COUNT_W-1:0] last_rundown
);
  import adc_pkg::*;

  seq_state_t state;

  // one clock counter shared by init, phase and done timing
  logic [COUNT_W-1:0] clk_cnt;
  logic [COUNT_W-1:0] phase_cnt;

  // live counts, the last_* copies are what the host sees
  logic [COUNT_W-1:0] count_up;
  logic [COUNT_W-1:0] count_down;
  logic [COUNT_W-1:0] count_rundown;

  // comparator sync, [1] is the usable level, [2] only for edge detect
  logic [2:0] cmp_sync;
  logic       cmp_now;
  logic       cmp_edge;

  logic init_done;
  logic phase_end;
  logic runup_last;
  logic detect;
  logic done_end;

  always_ff @(posedge clk)
  begin
    cmp_sync <= {cmp_sync[1:0], cmp_out};
  end

  assign cmp_now  = cmp_sync[1];
  // zero cross either way
  assign cmp_edge = cmp_sync[2] ^ cmp_sync[1];

  ////////////////////
  // state decode
  assign init_done  = (state == SEQ_INIT) && (clk_cnt == COUNT_W'(INIT_CLKS - 1));
  assign phase_end  = (state == SEQ_RUNUP) && (clk_cnt == COUNT_W'(PHASE_CLKS - 1));
  assign runup_last = phase_end && (phase_cnt == COUNT_W'(RUNUP_PHASES - 1));
  assign detect     = (state == SEQ_RUNDOWN) && cmp_edge;
  assign done_end   = (state == SEQ_DONE) && (clk_cnt == COUNT_W'(DONE_CLKS - 1));

  ////////////////////
  // control FSM
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state         <= SEQ_INIT;
      clk_cnt       <= '0;
      phase_cnt     <= '0;
      mux           <= MUX_OFF;
      cmp_latch_ctl <= 1'b1;
      interrupt_n   <= 1'b1;
    end
    else
    begin
      clk_cnt <= clk_cnt + 1'b1;

      case (state)
        SEQ_INIT:
        begin
          if (init_done)
          begin
            // release the comparator latch and start integrating up
            state         <= SEQ_RUNUP;
            clk_cnt       <= '0;
            phase_cnt     <= '0;
            mux           <= MUX_POS_REF;
            cmp_latch_ctl <= 1'b0;
          end
        end

        SEQ_RUNUP:
        begin
          if (phase_end)
          begin
            clk_cnt   <= '0;
            phase_cnt <= phase_cnt + 1'b1;
            // steer back toward zero, may repeat the same direction
            mux       <= cmp_now ? MUX_NEG_REF : MUX_POS_REF;
            // last direction carries on into the rundown
            if (runup_last)
              state <= SEQ_RUNDOWN;
          end
        end

        SEQ_RUNDOWN:
        begin
          if (detect)
          begin
            state         <= SEQ_DONE;
            clk_cnt       <= '0;
            mux           <= MUX_OFF;
            cmp_latch_ctl <= 1'b1;
            interrupt_n   <= 1'b0;
          end
        end

        SEQ_DONE:
        begin
          // hold the interrupt long enough for the host to see it
          if (done_end)
          begin
            state       <= SEQ_INIT;
            clk_cnt     <= '0;
            interrupt_n <= 1'b1;
          end
        end

        default:
          state <= SEQ_INIT;
      endcase
    end
  end

  ////////////////////
  // counts and snapshot
  always_ff @(posedge clk)
  begin
    if (init_done)
    begin
      count_up   <= '0;
      count_down <= '0;
    end
    else if (phase_end)
    begin
      if (cmp_now)
        count_up <= count_up + 1'b1;
      else
        count_down <= count_down + 1'b1;
    end

    // rundown counts every clk until the cross is seen
    if (runup_last)
      count_rundown <= '0;
    else if (state == SEQ_RUNDOWN)
      count_rundown <= count_rundown + 1'b1;

    // only updated on entry to done, so a read never sees a half result
    if (detect)
    begin
      last_up      <= count_up;
      last_down    <= count_down;
      last_rundown <= count_rundown;
    end
  end

  // every run-up phase lands in exactly one of the two counts
  a_snapshot_sum : assert property (@(posedge clk) disable iff (reset)
    (state == SEQ_DONE) |-> ((last_up + last_down) == COUNT_W'(RUNUP_PHASES)));

  // switch code is always a known one, and off outside integration
  a_mux_code : assert property (@(posedge clk) disable iff (reset)
    (mux inside {MUX_OFF, MUX_POS_REF, MUX_NEG_REF}) &&
    ((state inside {SEQ_RUNUP, SEQ_RUNDOWN}) || (mux == MUX_OFF)));

endmodule

// ==== hw/register_bank.sv ====
// host register bank, led control plus the three result counts
// read mux answers the port, writes land at frame end
`timescale 1ns/1ps

module register_bank (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        addr_valid,
  input  logic [adc_pkg::ADDR_W-1:0]  rd_addr,
  output logic [adc_pkg::COUNT_W-1:0] rd_data,
  input  logic                        frame_end,
  input  logic [adc_pkg::ADDR_W-1:0]  frame_addr,
  input  logic [adc_pkg::COUNT_W-1:0] frame_data,
  input  logic [adc_pkg::COUNT_W-1:0] last_up,
  input  logic [adc_pkg::COUNT_W-1:0] last_down,
  input  logic [adc_pkg::COUNT_W-1:0] last_rundown,
  output logic [adc_pkg::COUNT_W-1:0] led_reg
);
  import adc_pkg::*;

  logic [ADDR_W-1:0] rd_sel;
  logic              wr_en;

  // reads don't care about the read-only bit
  always_comb
  begin
    rd_sel                     = rd_addr;
    rd_sel[ADDR_READ_ONLY_BIT] = 1'b0;
  end

  // high address bit set means the host only wanted the read
  assign wr_en = frame_end && !frame_addr[ADDR_READ_ONLY_BIT];

  ////////////////////
  // read mux
  // registered, so the port picks it up one clk after addr_valid
  always_ff @(posedge clk)
  begin
    if (addr_valid)
    begin
      case (rd_sel)
        ADDR_LED:           rd_data <= led_reg;
        ADDR_COUNT_UP:      rd_data <= last_up;
        ADDR_COUNT_DOWN:    rd_data <= last_down;
        ADDR_COUNT_RUNDOWN: rd_data <= last_rundown;
        // unmapped reads give zero
        default:            rd_data <= '0;
      endcase
    end
  end

  ////////////////////
  // led register
  always_ff @(posedge clk)
  begin
    if (reset)
      led_reg <= LED_RESET_VALUE;
    else if (wr_en)
    begin
      case (frame_addr)
        ADDR_LED:
          led_reg <= frame_data;
        // soft reset, data field ignored
        ADDR_SOFT_RESET:
          led_reg <= LED_RESET_VALUE;
        default:
          led_reg <= led_reg;
      endcase
    end
  end

  // a read-only frame must not disturb the led value on the following clk
  a_read_only_frame : assert property (@(posedge clk) disable iff (reset)
    (frame_end && frame_addr[ADDR_READ_ONLY_BIT]) |=> $stable(led_reg));

endmodule

// ==== hw/spi_slave_port.sv ====
// spi slave port, pins oversampled in the clk domain
// shifts 32-bit frames in, serves register read data out on miso
`timescale 1ns/1ps

module spi_slave_port (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        sclk,
  input  logic                        cs_n,
  input  logic                        mosi,
  output logic                        miso,
  output logic                        addr_valid,
  output logic [adc_pkg::ADDR_W-1:0]  rd_addr,
  input  logic [adc_pkg::COUNT_W-1:0] rd_data,
  output logic                        frame_end,
  output logic [adc_pkg::ADDR_W-1:0]  frame_addr,
  output logic [adc_pkg::COUNT_W-1:0] frame_data
);
  import adc_pkg::*;

  // two flops of sync, the third stage is only for edge detect
  logic [2:0] sclk_sync;
  logic [2:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       cs_s;
  logic       mosi_s;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       cs_rise;

  // counts up to FRAME_BITS+1 and holds, so long frames never match
  logic [$clog2(FRAME_BITS):0] bit_cnt;
  logic [FRAME_BITS-1:0]       shift_in;
  logic [FRAME_BITS-1:0]       shift_out;
  logic                        load_pending;
  logic                        addr_done;
  logic                        frame_done;

  assign cs_s      = cs_sync[1];
  assign mosi_s    = mosi_sync[1];
  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign cs_rise   = cs_sync[1] & ~cs_sync[2];

  // address byte complete on this rising edge
  assign addr_done  = sclk_rise && !cs_s && (bit_cnt == ADDR_W - 1);
  // frame only counts when exactly FRAME_BITS were clocked
  assign frame_done = cs_rise && (bit_cnt == FRAME_BITS);

  ////////////////////
  // control and miso
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sclk_sync    <= '0;
      cs_sync      <= '1;
      bit_cnt      <= '0;
      addr_valid   <= 1'b0;
      load_pending <= 1'b0;
      shift_out    <= '0;
      miso         <= 1'b0;
      frame_end    <= 1'b0;
    end
    else
    begin
      sclk_sync    <= {sclk_sync[1:0], sclk};
      cs_sync      <= {cs_sync[1:0], cs_n};
      addr_valid   <= addr_done;
      frame_end    <= frame_done;
      // bank answers one clk after addr_valid
      load_pending <= addr_valid;

      if (cs_s)
      begin
        // idle between frames
        bit_cnt   <= '0;
        shift_out <= '0;
        miso      <= 1'b0;
      end
      else
      begin
        if (sclk_rise && (bit_cnt <= FRAME_BITS))
          bit_cnt <= bit_cnt + 1'b1;

        // read data lands well before the 8th falling edge
        if (load_pending)
          shift_out <= {rd_data, {ADDR_W{1'b0}}};
        else if (sclk_fall)
        begin
          // msb first, miso only moves on falling sclk
          miso      <= shift_out[FRAME_BITS-1];
          shift_out <= shift_out << 1;
        end
      end
    end
  end

  ////////////////////
  // data path
  always_ff @(posedge clk)
  begin
    mosi_sync <= {mosi_sync[0], mosi};

    if (sclk_rise && !cs_s)
      shift_in <= {shift_in[FRAME_BITS-2:0], mosi_s};

    if (addr_done)
      rd_addr <= {shift_in[ADDR_W-2:0], mosi_s};

    if (frame_done)
    begin
      frame_addr <= shift_in[FRAME_BITS-1 -: ADDR_W];
      frame_data <= shift_in[COUNT_W-1:0];
    end
  end

  // the host keeps cs_n low through the address byte and its read turnaround
  a_addr_in_frame : assert property (@(posedge clk) disable iff (reset)
    addr_valid |-> !cs_n);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the adc controller testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_adc_top --Mdir "$build_dir" -f sources.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

"./$build_dir/Vtb_adc_top" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Regression passed" "$log_file"; then
  exit 0
fi

echo "pass message not found in $log_file"
exit 1

// ==== sources.f ====
+incdir+verif
hw/adc_pkg.sv
hw/spi_slave_port.sv
hw/register_bank.sv
hw/modulation_sequencer.sv
hw/adc_top.sv
verif/tb_adc_top.sv

// ==== verif/tb_adc_tasks.svh ====
// shared testbench helpers for the adc controller
// lfsr stimulus, spi host transfer, bounded waits and check bookkeeping
`ifndef TB_ADC_TASKS_SVH
`define TB_ADC_TASKS_SVH

////////////////////
// testbench constants

localparam logic [31:0] LFSR_SEED = 32'he5937836;
// galois taps for x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h80200003;
// clk cycles per sclk level, port needs at least 4
localparam int SPI_HALF_CLKS       = 5;
localparam int IRQ_TIMEOUT_CLKS    = 2000;
localparam int TOGGLE_TIMEOUT_CLKS = 5000;
localparam int NUM_TESTS           = 6;

logic [31:0] lfsr_state = LFSR_SEED;

int    test_errors [NUM_TESTS] = '{default: 0};
int    test_checks [NUM_TESTS] = '{default: 0};
int    tests_done = 0;
string test_names [NUM_TESTS] = '{"reset_state", "led_write_read", "led_protect",
                                  "runup_steering", "result_counts", "back_to_back"};

////////////////////
// random bits

function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  // right shift form, taps fold back in when a one drops out
  return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
endfunction

// one lfsr step per bit, newest bit lands at the lsb
task automatic take_bits(input int count, output logic [31:0] value);
  int i;
  value = '0;
  for (i = 0; i < count; i++)
  begin
    lfsr_state = lfsr_step(lfsr_state);
    value      = {value[30:0], lfsr_state[0]};
  end
endtask

////////////////////
// checks

task automatic check_value(input int test_id, input string label,
                           input logic [31:0] expected, input logic [31:0] actual);
  test_checks[test_id]++;
  assert (actual == expected)
  else
  begin
    test_errors[test_id]++;
    $display("FAILED %0s %0s: expected %h actual %h",
             test_names[test_id], label, expected, actual);
  end
endtask

task automatic end_test(input int test_id);
  tests_done++;
  $display("test %0s: %0d checks, %0d errors",
           test_names[test_id], test_checks[test_id], test_errors[test_id]);
endtask

////////////////////
// spi host, mode 0, msb first
// call on a falling clk edge, returns on one

task automatic spi_transfer(input logic [7:0] addr, input logic [23:0] data,
                            output logic [23:0] rd);
  logic [31:0] tx;
  logic [31:0] rx;
  int          i;
  tx   = {addr, data};
  rx   = '0;
  cs_n = 1'b0;
  repeat (SPI_HALF_CLKS) @(negedge clk);
  for (i = 31; i >= 0; i--)
  begin
    mosi = tx[i];
    repeat (SPI_HALF_CLKS) @(negedge clk);
    // miso moved on the previous falling sclk, settled by now
    rx[i] = miso;
    sclk  = 1'b1;
    repeat (SPI_HALF_CLKS) @(negedge clk);
    sclk = 1'b0;
  end
  repeat (SPI_HALF_CLKS) @(negedge clk);
  cs_n = 1'b1;
  // leave room for frame_end and the register write
  repeat (2 * SPI_HALF_CLKS) @(negedge clk);
  rd = rx[23:0];
endtask

////////////////////
// bounded waits on the interrupt

task automatic wait_interrupt_low(input int timeout_clks);
  int waited;
  waited = 0;
  while (interrupt_n !== 1'b0)
  begin
    if (waited >= timeout_clks)
      abort_run("interrupt_n never fell after the comparator toggle");
    @(negedge clk);
    waited++;
  end
endtask

// counts falling edges with interrupt_n low, starting at the current one
task automatic measure_low_clks(output int width);
  width = 0;
  while ((interrupt_n === 1'b0) && (width < IRQ_TIMEOUT_CLKS))
  begin
    width++;
    @(negedge clk);
  end
endtask

`endif

// ==== verif/tb_adc_top.sv ====
// testbench for the multi-slope adc controller
// spi register access, comparator model and two full conversions
`timescale 1ns/1ps

module tb_adc_top;
  import adc_pkg::*;

  // host frame address with the read-only bit set
  localparam logic [ADDR_W-1:0] RD_FLAG = ADDR_W'(1) << ADDR_READ_ONLY_BIT;
  // synchronizer plus edge detect, seen in the rundown count
  localparam int DETECT_CLKS = 3;

  logic clk;
  logic reset;
  logic sclk;
  logic cs_n;
  logic mosi;
  logic miso;
  logic interrupt_n;
  logic cmp_out;
  logic int_in_p_ctl;
  logic int_in_n_ctl;
  logic int_in_sig_ctl;
  logic cmp_latch_ctl;
  logic led_r;
  logic led_g;
  logic led_b;
  logic [2:0] mux_pins;

  // host to comparator model, one grant per conversion allowed to finish
  int toggle_grants = 0;
  // model results, one slot per conversion
  int exp_up [2];
  int exp_down [2];
  int exp_rundown [2];

  assign mux_pins = {int_in_sig_ctl, int_in_n_ctl, int_in_p_ctl};

  task automatic abort_run(input string reason);
    $display("ERROR: %0s", reason);
    $display("Regression failed");
    $finish;
  endtask

  `include "tb_adc_tasks.svh"

  adc_top adc_top_i (
    .clk            (clk),
    .reset          (reset),
    .sclk           (sclk),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .miso           (miso),
    .interrupt_n    (interrupt_n),
    .cmp_out        (cmp_out),
    .int_in_p_ctl   (int_in_p_ctl),
    .int_in_n_ctl   (int_in_n_ctl),
    .int_in_sig_ctl (int_in_sig_ctl),
    .cmp_latch_ctl  (cmp_latch_ctl),
    .led_r          (led_r),
    .led_g          (led_g),
    .led_b          (led_b)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // interrupt pulse width, counted back from the rising edge
  a_irq_width : assert property (@(posedge clk) disable iff (reset)
    $rose(interrupt_n) |-> ($past(interrupt_n, DONE_CLKS + 1) && !$past(interrupt_n, DONE_CLKS)))
  else
  begin
    test_errors[5]++;
    $display("interrupt_n low pulse was not %0d clocks wide", DONE_CLKS);
  end

  ////////////////////
  // comparator model
  // one random level per run-up phase, one toggle per rundown
  initial
  begin : comparator_model
    logic        phase_high [RUNUP_PHASES];
    logic [31:0] bits;
    int          conv;
    int          phase;
    int          ups;
    int          delay;
    int          waited;

    cmp_out = 1'b0;
    waited  = 0;
    @(posedge clk);
    while (reset)
    begin
      if (waited > 100)
        abort_run("reset was never released");
      @(posedge clk);
      waited++;
    end
    // first falling edge of the init phase
    @(negedge clk);

    for (conv = 0; conv < 2; conv++)
    begin
      repeat (INIT_CLKS - 1) @(negedge clk);
      // run-up entry: latch released, integrate up first
      check_value(3, "mux at run-up entry", MUX_POS_REF, mux_pins);
      check_value(3, "latch at run-up entry", 0, cmp_latch_ctl);
      for (phase = 0; phase < RUNUP_PHASES; phase++)
      begin
        take_bits(1, bits);
        phase_high[phase] = bits[0];
        cmp_out           = bits[0];
        repeat (PHASE_CLKS) @(negedge clk);
        // phase end just passed, mux follows the sampled level
        check_value(3, "mux after phase end",
                    phase_high[phase] ? MUX_NEG_REF : MUX_POS_REF, mux_pins);
      end
      if (conv == 1)
        end_test(3);

      ups = 0;
      for (phase = 0; phase < RUNUP_PHASES; phase++)
        ups += int'(phase_high[phase]);

      // first clock the rundown counter counts
      @(negedge clk);
      delay = 0;
      // hold the rundown open until the host is ready for a result
      while (toggle_grants <= conv)
      begin
        if (delay >= TOGGLE_TIMEOUT_CLKS)
          abort_run("host never allowed the rundown to end");
        @(negedge clk);
        delay++;
      end
      take_bits(5, bits);
      delay += int'(bits[4:0]);
      repeat (bits[4:0]) @(negedge clk);

      exp_up[conv]      = ups;
      exp_down[conv]    = RUNUP_PHASES - ups;
      exp_rundown[conv] = delay + DETECT_CLKS;
      // zero cross
      cmp_out = ~cmp_out;
      // detect, done time, then the first clock of the next init
      repeat (8) @(negedge clk);
    end
  end

  ////////////////////
  // host sequence
  initial
  begin : host_sequence
    logic [31:0] bits;
    logic [23:0] led_val;
    logic [23:0] rd;
    int          i;
    int          conv;
    int          tid;
    int          width;
    int          total_checks;
    int          total_errors;

    reset = 1'b1;
    sclk  = 1'b0;
    cs_n  = 1'b1;
    mosi  = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // idle outputs through the whole init phase
    for (i = 0; i < INIT_CLKS; i++)
    begin
      check_value(0, "interrupt_n", 1, interrupt_n);
      check_value(0, "mux", MUX_OFF, mux_pins);
      check_value(0, "cmp_latch_ctl", 1, cmp_latch_ctl);
      check_value(0, "miso", 0, miso);
      @(negedge clk);
    end
    end_test(0);

    take_bits(24, bits);
    led_val = bits[23:0];
    spi_transfer(ADDR_LED, led_val, rd);
    check_value(1, "led pins", led_val[2:0], {led_b, led_g, led_r});
    spi_transfer(ADDR_LED | RD_FLAG, 24'h0, rd);
    check_value(1, "led readback", led_val, rd);
    end_test(1);

    // data in a read-only frame is dropped
    spi_transfer(ADDR_LED | RD_FLAG, ~led_val, rd);
    spi_transfer(ADDR_LED | RD_FLAG, 24'h0, rd);
    check_value(2, "led after read-only frame", led_val, rd);
    take_bits(24, bits);
    spi_transfer(ADDR_SOFT_RESET, bits[23:0], rd);
    spi_transfer(ADDR_LED | RD_FLAG, 24'h0, rd);
    check_value(2, "led after soft reset", LED_RESET_VALUE, rd);
    check_value(2, "led pins after soft reset", LED_RESET_VALUE[2:0], {led_b, led_g, led_r});
    end_test(2);

    // two conversions, each read out before the next may finish
    for (conv = 0; conv < 2; conv++)
    begin
      tid = (conv == 0) ? 4 : 5;
      toggle_grants++;
      wait_interrupt_low(IRQ_TIMEOUT_CLKS);
      check_value(5, "mux at result", MUX_OFF, mux_pins);
      check_value(5, "latch at result", 1, cmp_latch_ctl);
      measure_low_clks(width);
      check_value(5, "interrupt low clocks", DONE_CLKS, width);
      spi_transfer(ADDR_COUNT_UP | RD_FLAG, 24'h0, rd);
      check_value(tid, "count_up", exp_up[conv], rd);
      spi_transfer(ADDR_COUNT_DOWN | RD_FLAG, 24'h0, rd);
      check_value(tid, "count_down", exp_down[conv], rd);
      spi_transfer(ADDR_COUNT_RUNDOWN | RD_FLAG, 24'h0, rd);
      check_value(tid, "count_rundown", exp_rundown[conv], rd);
      if (conv == 0)
        end_test(4);
    end
    end_test(5);

    total_checks = 0;
    total_errors = 0;
    for (i = 0; i < NUM_TESTS; i++)
    begin
      total_checks += test_checks[i];
      total_errors += test_errors[i];
    end
    $display("tests %0d, checks %0d, errors %0d", tests_done, total_checks, total_errors);
    if (total_errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule
